// File: hdl/msx_pkg.sv
`default_nettype none

package msx_pkg;

    // Host option status word and the 16-bit words it is written in.
    typedef logic [63:0] status_word_t;
    typedef logic [15:0] status_half_t;

    // Raw menu selector widths inside the status word.
    typedef logic [2:0] slot_sel_t;
    typedef logic [3:0] mapper_sel_t;

    // SRAM size in kB, 0 when the cartridge has none.
    typedef logic [7:0] sram_size_t;

    // Cartridge SRAM byte address, up to 32 kB.
    typedef logic [14:0] cart_addr_t;

    typedef enum logic [2:0] {
        CART_TYP_ROM   = 3'd0,
        CART_TYP_SCC   = 3'd1,
        CART_TYP_SCC2  = 3'd2,
        CART_TYP_FMPAC = 3'd3,
        CART_TYP_MFRSD = 3'd4,
        CART_TYP_GM2   = 3'd5,
        CART_TYP_FDC   = 3'd6,
        CART_TYP_EMPTY = 3'd7
    } cart_typ_t;

    // Menu selector plus two, wrapping at 16.
    typedef enum logic [3:0] {
        MAPPER_RSVD0      = 4'd0,
        MAPPER_NONE       = 4'd1,
        MAPPER_AUTO       = 4'd2,
        MAPPER_SEL_NONE   = 4'd3,
        MAPPER_ASCII8     = 4'd4,
        MAPPER_ASCII16    = 4'd5,
        MAPPER_KONAMI     = 4'd6,
        MAPPER_KONAMI_SCC = 4'd7,
        MAPPER_KOEI       = 4'd8,
        MAPPER_LINEAR64   = 4'd9,
        MAPPER_RTYPE      = 4'd10,
        MAPPER_WIZARDRY   = 4'd11,
        MAPPER_RSVD12     = 4'd12,
        MAPPER_RSVD13     = 4'd13,
        MAPPER_RSVD14     = 4'd14,
        MAPPER_RSVD15     = 4'd15
    } mapper_typ_t;

    typedef struct packed {
        cart_typ_t   typ;
        mapper_typ_t selected_mapper;
        sram_size_t  selected_sram_size;
    } cart_config_t;

    typedef enum logic {
        MSX1 = 1'b0,
        MSX2 = 1'b1
    } msx_typ_t;

    typedef enum logic [1:0] {
        VIDEO_AUTO = 2'd0,
        VIDEO_PAL  = 2'd1,
        VIDEO_NTSC = 2'd2,
        VIDEO_RSVD = 2'd3
    } video_mode_t;

    typedef enum logic {
        CAS_AUDIO_FILE = 1'b0,
        CAS_AUDIO_ADC  = 1'b1
    } cas_audio_src_t;

    typedef struct packed {
        msx_typ_t msx_typ;
        logic     use_fdc;
    } bios_config_t;

    typedef struct packed {
        msx_typ_t       typ;
        logic           scandoubler;
        video_mode_t    video_mode;
        cas_audio_src_t cas_audio_src;
        logic           border;
    } user_config_t;

    // Field positions in the status word.
    localparam int SLOT_A_SEL_LSB = 17;
    localparam int SLOT_B_SEL_LSB = 29;
    localparam int SRAM_A_SEL_LSB = 26;
    localparam int MAPPER_A_LSB   = 20;
    localparam int MAPPER_B_LSB   = 32;
    localparam int VIDEO_MSX1_BIT = 12;
    localparam int VIDEO_MODE_LSB = 13;
    localparam int CAS_AUDIO_BIT  = 8;
    localparam int BORDER_BIT     = 41;

    // Length of the emulated machine reset, in clock cycles.
    localparam int CORE_RESET_CYCLES = 16;

    typedef logic [$clog2(CORE_RESET_CYCLES + 1)-1:0] rst_count_t;

endpackage

`default_nettype wire

// File: hdl/status_regs.sv
`default_nettype none

module status_regs (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   status_we,
    input  wire logic [1:0]             status_addr,
    input  wire msx_pkg::status_half_t  status_wdata,
    input  wire logic                   status_commit,
    output msx_pkg::status_word_t       status
);

    import msx_pkg::*;

    // Word 0 holds bits 15:0, word 3 holds bits 63:48.
    status_half_t [3:0] stage;

    // Host writes land here first.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage <= '0;
        end else if (status_we) begin
            stage[status_addr] <= status_wdata;
        end
    end

    // All 64 bits move together, so the decoder never sees a torn update.
    // A write in the commit cycle is not part of this commit.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status <= '0;
        end else if (status_commit) begin
            status <= stage;
        end
    end

endmodule

`default_nettype wire

// File: hdl/msx_config.sv
`default_nettype none

module msx_config (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire msx_pkg::bios_config_t  bios_config,
    input  wire msx_pkg::status_word_t  status,
    input  wire logic                   scandoubler,
    input  wire logic [1:0]             rom_loaded,
    output msx_pkg::cart_config_t [1:0] cart_conf,
    output msx_pkg::user_config_t       user_config,
    output logic                        rom_a_load_hide,
    output logic                        rom_b_load_hide,
    output logic                        sram_a_select_hide,
    output logic                        fdc_enabled,
    output logic                        reload
);

    import msx_pkg::*;

    // Everything that requires the cartridges to be reloaded.
    typedef struct packed {
        cart_typ_t   typ_b;
        cart_typ_t   typ_a;
        mapper_typ_t mapper_a;
        mapper_typ_t mapper_b;
        slot_sel_t   sram_a_sel;
    } change_vec_t;

    slot_sel_t   slot_a_sel;
    slot_sel_t   slot_b_sel;
    slot_sel_t   sram_a_sel;
    mapper_sel_t mapper_a_sel;
    mapper_sel_t mapper_b_sel;

    cart_typ_t   typ_a;
    cart_typ_t   typ_b;
    change_vec_t change_now;
    change_vec_t change_last;
    logic        primed;

    assign slot_a_sel   = status[SLOT_A_SEL_LSB +: 3];
    assign slot_b_sel   = status[SLOT_B_SEL_LSB +: 3];
    assign sram_a_sel   = status[SRAM_A_SEL_LSB +: 3];
    assign mapper_a_sel = status[MAPPER_A_LSB +: 4];
    assign mapper_b_sel = status[MAPPER_B_LSB +: 4];

    // With the BIOS FDC in use, the FDC entry disappears from slot A.
    always_comb begin
        if (slot_a_sel < CART_TYP_FDC) begin
            typ_a = cart_typ_t'(slot_a_sel);
        end else if (bios_config.use_fdc) begin
            typ_a = CART_TYP_EMPTY;
        end else if (slot_a_sel == CART_TYP_FDC) begin
            typ_a = CART_TYP_FDC;
        end else begin
            typ_a = CART_TYP_EMPTY;
        end
    end

    // Slot B offers only the first four types.
    assign typ_b = (slot_b_sel < CART_TYP_MFRSD) ? cart_typ_t'(slot_b_sel) : CART_TYP_EMPTY;

    always_comb begin
        cart_conf[0].typ = typ_a;
        cart_conf[1].typ = typ_b;

        cart_conf[0].selected_mapper = rom_loaded[0] ?
            mapper_typ_t'(mapper_a_sel + 4'd2) : MAPPER_NONE;
        cart_conf[1].selected_mapper = rom_loaded[1] ?
            mapper_typ_t'(mapper_b_sel + 4'd2) : MAPPER_NONE;

        // Selector 1..6 maps to 1 kB..32 kB.
        if (typ_a == CART_TYP_ROM && mapper_a_sel > 4'd1 &&
            sram_a_sel > 3'd0 && sram_a_sel < 3'd7) begin
            cart_conf[0].selected_sram_size = sram_size_t'(1) << (sram_a_sel - 3'd1);
        end else begin
            cart_conf[0].selected_sram_size = '0;
        end
        cart_conf[1].selected_sram_size = '0;
    end

    always_comb begin
        user_config.typ         = bios_config.msx_typ;
        user_config.scandoubler = scandoubler;
        if (bios_config.msx_typ == MSX1) begin
            user_config.video_mode = status[VIDEO_MSX1_BIT] ? VIDEO_NTSC : VIDEO_PAL;
        end else begin
            user_config.video_mode = video_mode_t'(status[VIDEO_MODE_LSB +: 2]);
        end
        user_config.cas_audio_src = cas_audio_src_t'(status[CAS_AUDIO_BIT]);
        user_config.border        = status[BORDER_BIT];
    end

    assign rom_a_load_hide    = typ_a != CART_TYP_ROM;
    assign rom_b_load_hide    = typ_b != CART_TYP_ROM;
    assign sram_a_select_hide = (typ_a != CART_TYP_ROM) || (mapper_a_sel == 4'd0);
    assign fdc_enabled        = bios_config.use_fdc || (typ_a == CART_TYP_FDC);

    assign change_now = '{
        typ_b:      typ_b,
        typ_a:      typ_a,
        mapper_a:   cart_conf[0].selected_mapper,
        mapper_b:   cart_conf[1].selected_mapper,
        sram_a_sel: sram_a_sel
    };

    // First cycle out of reset only loads the copy.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            primed      <= 1'b0;
            change_last <= '0;
            reload      <= 1'b0;
        end else begin
            primed      <= 1'b1;
            change_last <= change_now;
            reload      <= primed && (change_now != change_last);
        end
    end

endmodule

`default_nettype wire

// File: hdl/reset_sequencer.sv
`default_nettype none

module reset_sequencer (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic reload,
    output logic      core_rst_n
);

    import msx_pkg::*;

    rst_count_t count;

    // Reload restarts the count even when one is already running.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= rst_count_t'(CORE_RESET_CYCLES);
        end else if (reload) begin
            count <= rst_count_t'(CORE_RESET_CYCLES);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Core stays in reset while cycles remain.
    assign core_rst_n = (count == '0);

endmodule

`default_nettype wire

// File: hdl/sram_window.sv
`default_nettype none

module sram_window (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire msx_pkg::sram_size_t  sram_size,
    input  wire logic                 sram_req,
    input  wire msx_pkg::cart_addr_t  cart_sram_addr,
    output logic                      sram_valid,
    output msx_pkg::cart_addr_t       sram_mem_addr
);

    import msx_pkg::*;

    logic [17:0] size_bytes;
    logic [17:0] limit_mask;
    logic        has_sram;

    // Sizes are powers of two, so size in bytes minus one is the mask.
    assign size_bytes = {sram_size, 10'd0};
    assign limit_mask = size_bytes - 18'd1;
    assign has_sram   = sram_size != '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sram_valid <= 1'b0;
        end else begin
            sram_valid <= sram_req && has_sram;
        end
    end

    // Address wraps inside the selected window.
    always_ff @(posedge clk) begin
        if (sram_req) begin
            sram_mem_addr <= cart_sram_addr & limit_mask[14:0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/msx_setup.sv
`default_nettype none

module msx_setup (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   status_we,
    input  wire logic [1:0]             status_addr,
    input  wire msx_pkg::status_half_t  status_wdata,
    input  wire logic                   status_commit,
    input  wire msx_pkg::bios_config_t  bios_config,
    input  wire logic                   scandoubler,
    input  wire logic [1:0]             rom_loaded,
    input  wire logic                   sram_req,
    input  wire msx_pkg::cart_addr_t    cart_sram_addr,
    output msx_pkg::cart_config_t [1:0] cart_conf,
    output msx_pkg::user_config_t       user_config,
    output logic                        rom_a_load_hide,
    output logic                        rom_b_load_hide,
    output logic                        sram_a_select_hide,
    output logic                        fdc_enabled,
    output logic                        reload,
    output logic                        core_rst_n,
    output logic                        sram_valid,
    output msx_pkg::cart_addr_t         sram_mem_addr
);

    import msx_pkg::*;

    status_word_t status;

    status_regs u_status_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .status_we     (status_we),
        .status_addr   (status_addr),
        .status_wdata  (status_wdata),
        .status_commit (status_commit),
        .status        (status)
    );

    msx_config u_msx_config (
        .clk                (clk),
        .rst_n              (rst_n),
        .bios_config        (bios_config),
        .status             (status),
        .scandoubler        (scandoubler),
        .rom_loaded         (rom_loaded),
        .cart_conf          (cart_conf),
        .user_config        (user_config),
        .rom_a_load_hide    (rom_a_load_hide),
        .rom_b_load_hide    (rom_b_load_hide),
        .sram_a_select_hide (sram_a_select_hide),
        .fdc_enabled        (fdc_enabled),
        .reload             (reload)
    );

    reset_sequencer u_reset_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .reload     (reload),
        .core_rst_n (core_rst_n)
    );

    sram_window u_sram_window (
        .clk            (clk),
        .rst_n          (rst_n),
        .sram_size      (cart_conf[0].selected_sram_size),
        .sram_req       (sram_req),
        .cart_sram_addr (cart_sram_addr),
        .sram_valid     (sram_valid),
        .sram_mem_addr  (sram_mem_addr)
    );

endmodule

`default_nettype wire

// File: tests/msx_setup_properties.sv
`default_nettype none

module msx_setup_properties (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic reload,
    input wire logic core_rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    import msx_pkg::*;

    int fail_count = 0;

    // Reload is a single-cycle pulse.
    reload_single: assert property (@(posedge clk) disable iff (!rst_n)
        reload |=> !reload)
        else begin
            $error("reload stayed high for two cycles");
            fail_count++;
        end

    // Core reset drops right after the edge that samples reload.
    reset_falls: assert property (@(posedge clk) disable iff (!rst_n)
        reload |=> !core_rst_n)
        else begin
            $error("core_rst_n did not fall after reload");
            fail_count++;
        end

    reset_held: assert property (@(posedge clk) disable iff (!rst_n)
        reload |=> (!core_rst_n) [*CORE_RESET_CYCLES])
        else begin
            $error("core_rst_n released before the full reset count");
            fail_count++;
        end

    // Without a new reload the core leaves reset right after the count.
    reset_released: assert property (@(posedge clk) disable iff (!rst_n)
        reload ##1 (!reload) [*CORE_RESET_CYCLES] |=> core_rst_n)
        else begin
            $error("core_rst_n stayed low past the reset count");
            fail_count++;
        end

endmodule

// Reload enters the sequencer from msx_config.
bind reset_sequencer msx_setup_properties u_msx_setup_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .reload     (reload),
    .core_rst_n (core_rst_n)
);

`default_nettype wire

// File: tests/tb_msx_setup.sv
`default_nettype none

module tb_msx_setup;

    timeunit 1ns;
    timeprecision 1ps;

    import msx_pkg::*;

    typedef struct packed {
        logic [2:0] slot_a;
        logic [3:0] map_a;
        logic [2:0] sram_sel;
        logic [2:0] slot_b;
        logic [3:0] map_b;
        logic [2:0] vid;
        logic       cas;
        logic       border;
        logic [1:0] bios;
        logic [1:0] rom;
        logic [2:0] exp_typ_a;
        logic [2:0] exp_typ_b;
        logic [3:0] exp_map_a;
        logic [3:0] exp_map_b;
        logic [7:0] exp_size;
        logic [3:0] exp_flags;
        logic [1:0] exp_video;
        logic       exp_reload;
    } row_t;

    logic               clk;
    logic               rst_n;
    logic               status_we;
    logic [1:0]         status_addr;
    status_half_t       status_wdata;
    logic               status_commit;
    bios_config_t       bios_config;
    logic               scandoubler;
    logic [1:0]         rom_loaded;
    logic               sram_req;
    cart_addr_t         cart_sram_addr;
    cart_config_t [1:0] cart_conf;
    user_config_t       user_config;
    logic               rom_a_load_hide;
    logic               rom_b_load_hide;
    logic               sram_a_select_hide;
    logic               fdc_enabled;
    logic               reload;
    logic               core_rst_n;
    logic               sram_valid;
    cart_addr_t         sram_mem_addr;

    int          errors;
    logic [31:0] rng;

    // Selectors: slot A, mapper A, SRAM, slot B, mapper B, status bits 14:12, cassette,
    // border, {msx_typ, use_fdc}, rom_loaded. Expected: slot A and B types, mappers,
    // SRAM kB, {rom A hide, rom B hide, SRAM hide, FDC}, video mode, reload.
    row_t rows [27] = '{
        '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 4'b0010, 1, 0},
        '{1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1, 1, 0, 4'b1010, 1, 1},
        '{2, 0, 0, 4, 0, 0, 0, 0, 0, 0, 2, 7, 1, 1, 0, 4'b1110, 1, 1},
        '{3, 0, 0, 5, 0, 0, 0, 0, 0, 0, 3, 7, 1, 1, 0, 4'b1110, 1, 1},
        '{4, 0, 0, 6, 0, 0, 0, 0, 0, 0, 4, 7, 1, 1, 0, 4'b1110, 1, 1},
        '{5, 0, 0, 7, 0, 0, 0, 0, 0, 0, 5, 7, 1, 1, 0, 4'b1110, 1, 1},
        '{6, 0, 0, 3, 0, 0, 0, 0, 0, 0, 6, 3, 1, 1, 0, 4'b1111, 1, 1},
        '{7, 0, 0, 0, 0, 0, 0, 0, 0, 0, 7, 0, 1, 1, 0, 4'b1010, 1, 1},
        '{6, 0, 0, 0, 0, 0, 0, 0, 1, 0, 7, 0, 1, 1, 0, 4'b1011, 1, 0},
        '{7, 0, 0, 0, 0, 0, 0, 0, 1, 0, 7, 0, 1, 1, 0, 4'b1011, 1, 0},
        '{2, 0, 0, 0, 0, 0, 0, 0, 1, 0, 2, 0, 1, 1, 0, 4'b1011, 1, 1},
        '{0, 2, 1, 0, 5, 0, 0, 0, 1, 0, 0, 0, 1, 1, 1, 4'b0001, 1, 1},
        '{0, 2, 2, 0, 5, 0, 0, 0, 0, 3, 0, 0, 4, 7, 2, 4'b0000, 1, 1},
        '{0, 2, 3, 0, 5, 0, 0, 0, 0, 3, 0, 0, 4, 7, 4, 4'b0000, 1, 1},
        '{0, 2, 4, 0, 5, 0, 0, 0, 0, 3, 0, 0, 4, 7, 8, 4'b0000, 1, 1},
        '{0, 2, 5, 0, 5, 0, 0, 0, 0, 3, 0, 0, 4, 7, 16, 4'b0000, 1, 1},
        '{0, 2, 6, 0, 5, 0, 0, 0, 0, 3, 0, 0, 4, 7, 32, 4'b0000, 1, 1},
        '{0, 2, 7, 0, 5, 0, 0, 0, 0, 3, 0, 0, 4, 7, 0, 4'b0000, 1, 1},
        '{0, 2, 0, 0, 5, 0, 0, 0, 0, 3, 0, 0, 4, 7, 0, 4'b0000, 1, 1},
        '{0, 1, 3, 0, 5, 0, 0, 0, 0, 3, 0, 0, 3, 7, 0, 4'b0000, 1, 1},
        '{0, 0, 3, 0, 5, 0, 0, 0, 0, 3, 0, 0, 2, 7, 0, 4'b0010, 1, 1},
        '{0, 15, 3, 0, 14, 0, 0, 0, 0, 3, 0, 0, 1, 0, 4, 4'b0000, 1, 1},
        '{0, 15, 3, 0, 14, 0, 0, 0, 0, 1, 0, 0, 1, 1, 4, 4'b0000, 1, 1},
        '{0, 15, 3, 0, 14, 1, 1, 1, 0, 1, 0, 0, 1, 1, 4, 4'b0000, 2, 0},
        '{0, 15, 3, 0, 14, 6, 0, 0, 2, 1, 0, 0, 1, 1, 4, 4'b0000, 3, 0},
        '{0, 15, 3, 0, 14, 5, 0, 0, 2, 1, 0, 0, 1, 1, 4, 4'b0000, 2, 0},
        '{0, 15, 3, 0, 14, 6, 0, 0, 0, 1, 0, 0, 1, 1, 4, 4'b0000, 1, 0}
    };

    msx_setup u_msx_setup (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Field positions as the host menu lays them out.
    function automatic status_word_t build_status(row_t r);
        status_word_t w;
        w        = '0;
        w[19:17] = r.slot_a;
        w[23:20] = r.map_a;
        w[28:26] = r.sram_sel;
        w[31:29] = r.slot_b;
        w[35:32] = r.map_b;
        w[14:12] = r.vid;
        w[8]     = r.cas;
        w[41]    = r.border;
        return w;
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] want);
        if (got !== want) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
        end
    endtask

    task automatic write_status(status_word_t w);
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #2;
            status_we    = 1'b1;
            status_addr  = i[1:0];
            status_wdata = w[16*i +: 16];
        end
        @(posedge clk);
        #2;
        status_we = 1'b0;
    endtask

    // BIOS and ROM inputs change with the live word, as seen by the next edge.
    task automatic commit_status(bios_config_t bios, logic [1:0] rom, logic sd);
        @(posedge clk);
        #2;
        status_commit = 1'b1;
        @(posedge clk);
        #2;
        status_commit = 1'b0;
        bios_config   = bios;
        rom_loaded    = rom;
        scandoubler   = sd;
    endtask

    task automatic watch_reload(logic want_pulse);
        int limit;
        bit seen;
        limit = want_pulse ? 8 : 4;
        seen  = 1'b0;
        for (int n = 0; n < limit && !seen; n++) begin
            @(negedge clk);
            seen = reload;
        end
        if (want_pulse && !seen) begin
            errors++;
            $display("Timed out waiting for the reload pulse");
        end else if (!want_pulse && seen) begin
            errors++;
            $display("Reload pulsed although no cartridge setting changed");
        end
    endtask

    task automatic check_row(row_t r, logic sd);
        check_value("cart_conf[0].typ", cart_conf[0].typ, r.exp_typ_a);
        check_value("cart_conf[1].typ", cart_conf[1].typ, r.exp_typ_b);
        check_value("cart_conf[0].selected_mapper", cart_conf[0].selected_mapper, r.exp_map_a);
        check_value("cart_conf[1].selected_mapper", cart_conf[1].selected_mapper, r.exp_map_b);
        check_value("cart_conf[0].selected_sram_size", cart_conf[0].selected_sram_size,
                    r.exp_size);
        check_value("cart_conf[1].selected_sram_size", cart_conf[1].selected_sram_size, 0);
        check_value("rom_a_load_hide", rom_a_load_hide, r.exp_flags[3]);
        check_value("rom_b_load_hide", rom_b_load_hide, r.exp_flags[2]);
        check_value("sram_a_select_hide", sram_a_select_hide, r.exp_flags[1]);
        check_value("fdc_enabled", fdc_enabled, r.exp_flags[0]);
        check_value("user_config", user_config,
                    {r.bios[1], sd, r.exp_video, r.cas, r.border});
    endtask

    // Back-to-back requests, each answered one cycle later.
    task automatic run_sram_requests(int kb);
        cart_addr_t mask;
        cart_addr_t prev_addr;
        mask      = cart_addr_t'(kb * 1024 - 1);
        prev_addr = '0;
        for (int k = 0; k <= 6; k++) begin
            @(posedge clk);
            #2;
            sram_req       = (k < 6);
            cart_sram_addr = cart_addr_t'(xorshift32());
            @(negedge clk);
            check_value("sram_valid", sram_valid, (k > 0) && (kb != 0));
            if (k > 0 && kb != 0) begin
                check_value("sram_mem_addr", sram_mem_addr, prev_addr & mask);
            end
            prev_addr = cart_sram_addr;
        end
    endtask

    initial begin
        row_t         r;
        status_word_t w;
        int           low_cycles;
        bit           released;
        int           kb;
        int           assert_errors;
        clk            = 1'b0;
        rst_n          = 1'b0;
        status_we      = 1'b0;
        status_addr    = '0;
        status_wdata   = '0;
        status_commit  = 1'b0;
        bios_config    = '0;
        scandoubler    = 1'b0;
        rom_loaded     = '0;
        sram_req       = 1'b0;
        cart_sram_addr = '0;
        errors         = 0;
        rng            = 32'd40454;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        low_cycles = 0;
        released   = 1'b0;
        for (int n = 0; n < 64 && !released; n++) begin
            @(negedge clk);
            check_value("reload", reload, 1'b0);
            if (core_rst_n) begin
                released = 1'b1;
            end else begin
                low_cycles++;
            end
        end
        if (!released) begin
            errors++;
            $display("Timed out waiting for core_rst_n to rise after reset");
        end
        check_value("core_rst_n low cycles", low_cycles, CORE_RESET_CYCLES);

        foreach (rows[i]) begin
            write_status(build_status(rows[i]));
            commit_status(rows[i].bios, rows[i].rom, i[0]);
            watch_reload(rows[i].exp_reload);
            @(negedge clk);
            check_row(rows[i], i[0]);
        end

        // Staged words stay invisible until a commit.
        r        = rows[26];
        r.slot_a = 3'd3;
        write_status(build_status(r));
        watch_reload(1'b0);
        check_value("cart_conf[0].typ", cart_conf[0].typ, 3'd0);
        r.slot_a = 3'd5;
        w        = build_status(r);
        @(posedge clk);
        #2;
        status_we     = 1'b1;
        status_addr   = 2'd1;
        status_wdata  = w[31:16];
        status_commit = 1'b1;
        @(posedge clk);
        #2;
        status_we     = 1'b0;
        status_commit = 1'b0;
        watch_reload(1'b1);
        check_value("cart_conf[0].typ", cart_conf[0].typ, 3'd3);
        commit_status(r.bios, r.rom, 1'b0);
        watch_reload(1'b1);
        check_value("cart_conf[0].typ", cart_conf[0].typ, 3'd5);

        for (int s = 0; s < 8; s++) begin
            r          = rows[26];
            r.sram_sel = s[2:0];
            write_status(build_status(r));
            commit_status(r.bios, r.rom, 1'b0);
            kb = (s >= 1 && s <= 6) ? (1 << (s - 1)) : 0;
            @(negedge clk);
            check_value("cart_conf[0].selected_sram_size", cart_conf[0].selected_sram_size, kb);
            run_sram_requests(kb);
        end

        assert_errors = u_msx_setup.u_reset_sequencer.u_msx_setup_properties.fail_count;
        $display("Errors: %0d, assertion failures: %0d", errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: msx_setup.f
hdl/msx_pkg.sv
hdl/status_regs.sv
hdl/msx_config.sv
hdl/reset_sequencer.sv
hdl/sram_window.sv
hdl/msx_setup.sv
tests/msx_setup_properties.sv
tests/tb_msx_setup.sv

// File: Bender.yml
package:
  name: msx_setup

sources:
  - files:
      - hdl/msx_pkg.sv
      - hdl/status_regs.sv
      - hdl/msx_config.sv
      - hdl/reset_sequencer.sv
      - hdl/sram_window.sv
      - hdl/msx_setup.sv
  - target: test
    files:
      - tests/msx_setup_properties.sv
      - tests/tb_msx_setup.sv
